//--- hw/byte_intake.sv
`timescale 1ns/1ps

module byte_intake import stream_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_strobe,     // one cycle per byte
    input  byte_t                       in_byte,
    input  logic                        fifo_full,     // byte fifo status
    output logic                        fifo_wr_en,
    output byte_t                       fifo_wr_data,
    output logic [DROP_COUNT_WIDTH-1:0] drop_count     // saturating
);

    logic  strobe_q;  // registered strobe in cycle n+1
    byte_t byte_q;    // registered byte

    // input register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= in_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (in_strobe) begin
            byte_q <= in_byte;  // loaded only on a strobe
        end
    end

    // write straight into the fifo unless it is full
    assign fifo_wr_en   = strobe_q && !fifo_full;
    assign fifo_wr_data = byte_q;

    // drop accounting
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (strobe_q && fifo_full && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;  // stops at max
        end
    end

endmodule

//--- hw/byte_packer.sv
`timescale 1ns/1ps

module byte_packer import stream_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    // byte fifo read side
    input  logic  byte_empty,
    output logic  byte_rd_en,
    input  byte_t byte_rd_data,    // valid one cycle after byte_rd_en
    // word fifo write side
    input  logic  word_full,
    output logic  word_wr_en,      // marks the end of a pair
    output word_t word_wr_data
);

    typedef enum logic [2:0] {
        S_RD_LO,   // pop first byte
        S_CAP_LO,  // first byte on read port
        S_RD_HI,   // pop second byte
        S_CAP_HI,  // second byte on read port, build word
        S_PUSH     // wait for room in word fifo
    } state_t;

    state_t state;
    state_t state_next;

    byte_t lo_q;    // first byte of the pair
    word_t word_q;  // assembled word with parity

    // next state
    always_comb begin
        state_next = state;
        case (state)
            S_RD_LO: begin
                if (!byte_empty) begin
                    state_next = S_CAP_LO;
                end
            end
            S_CAP_LO: state_next = S_RD_HI;
            S_RD_HI: begin
                if (!byte_empty) begin
                    state_next = S_CAP_HI;
                end
            end
            S_CAP_HI: state_next = S_PUSH;
            S_PUSH: begin
                if (!word_full) begin
                    state_next = S_RD_LO;  // pair done
                end
            end
            default: state_next = S_RD_LO;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_RD_LO;
        end else begin
            state <= state_next;
        end
    end

    // pops only when a byte is there
    assign byte_rd_en = ((state == S_RD_LO) || (state == S_RD_HI)) && !byte_empty;

    // payload capture, no reset needed
    always_ff @(posedge clk) begin
        if (state == S_CAP_LO) begin
            lo_q <= byte_rd_data;
        end
        if (state == S_CAP_HI) begin
            word_q.data   <= {byte_rd_data, lo_q};  // first byte low
            word_q.parity <= ^{byte_rd_data, lo_q}; // even total over 17 bits
        end
    end

    // push once there is space
    assign word_wr_en   = (state == S_PUSH) && !word_full;
    assign word_wr_data = word_q;

    // a word only leaves after both halves went through capture
    a_push_only_after_pair : assert property (
        @(posedge clk) disable iff (rst)
        word_wr_en |-> (state == S_PUSH) && ($past(state) inside {S_CAP_HI, S_PUSH})
    ) else $error("byte_packer: word push outside push state");

endmodule

//--- hw/stream_packer_top.sv
`timescale 1ns/1ps

module stream_packer_top import stream_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_strobe,
    input  byte_t                       in_byte,
    input  logic                        hold,
    output logic                        out_strobe,
    output logic [WORD_DATA_WIDTH-1:0]  out_word,
    output logic                        out_parity,
    output logic [DROP_COUNT_WIDTH-1:0] drop_count,
    output logic                        in_almost_full,   // byte fifo status
    output logic                        out_almost_empty  // word fifo status
);

    // byte fifo links
    logic  byte_wr_en;
    byte_t byte_wr_data;
    logic  byte_full;
    logic  byte_rd_en;
    byte_t byte_rd_data;
    logic  byte_empty;

    // word fifo links
    logic  word_wr_en;
    word_t word_wr_data;
    logic  word_full;
    logic  word_rd_en;
    word_t word_rd_data;
    logic  word_empty;

    byte_intake u_byte_intake (
        .clk          (clk),
        .rst          (rst),
        .in_strobe    (in_strobe),
        .in_byte      (in_byte),
        .fifo_full    (byte_full),
        .fifo_wr_en   (byte_wr_en),
        .fifo_wr_data (byte_wr_data),
        .drop_count   (drop_count)
    );

    sync_fifo #(
        .payload_t (byte_t),
        .DEPTH     (BYTE_FIFO_DEPTH)
    ) u_byte_fifo (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (byte_wr_en),
        .wr_data      (byte_wr_data),
        .rd_en        (byte_rd_en),
        .rd_data      (byte_rd_data),
        .empty        (byte_empty),
        .full         (byte_full),
        .almost_full  (in_almost_full),
        .almost_empty ()                 // not used on the byte side
    );

    byte_packer u_byte_packer (
        .clk          (clk),
        .rst          (rst),
        .byte_empty   (byte_empty),
        .byte_rd_en   (byte_rd_en),
        .byte_rd_data (byte_rd_data),
        .word_full    (word_full),
        .word_wr_en   (word_wr_en),
        .word_wr_data (word_wr_data)
    );

    sync_fifo #(
        .payload_t (word_t),
        .DEPTH     (WORD_FIFO_DEPTH)
    ) u_word_fifo (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (word_wr_en),
        .wr_data      (word_wr_data),
        .rd_en        (word_rd_en),
        .rd_data      (word_rd_data),
        .empty        (word_empty),
        .full         (word_full),
        .almost_full  (),                // not used on the word side
        .almost_empty (out_almost_empty)
    );

    word_pacer u_word_pacer (
        .clk          (clk),
        .rst          (rst),
        .hold         (hold),
        .word_empty   (word_empty),
        .word_rd_en   (word_rd_en),
        .word_rd_data (word_rd_data),
        .out_strobe   (out_strobe),
        .out_word     (out_word),
        .out_parity   (out_parity)
    );

endmodule

//--- hw/stream_pkg.sv
package stream_pkg;

    // stream widths
    localparam int BYTE_WIDTH      = 8;
    localparam int WORD_DATA_WIDTH = 2 * BYTE_WIDTH;  // two bytes per word

    // fifo sizing
    localparam int BYTE_FIFO_DEPTH = 21;  // not a power of two, pointers wrap by compare
    localparam int WORD_FIFO_DEPTH = 8;   // 16 bytes of buffering

    // status thresholds, shared by both fifos
    localparam int FIFO_AF_THRESHOLD = 6;  // almost full when free entries <= this
    localparam int FIFO_AE_THRESHOLD = 1;  // almost empty when occupancy <= this

    // output pacing
    localparam int PACE_CYCLES    = 4;                     // min cycles between strobes
    localparam int PACE_CNT_WIDTH = $clog2(PACE_CYCLES);   // counter holds 0..PACE_CYCLES-1

    // overflow accounting
    localparam int DROP_COUNT_WIDTH = 16;  // saturates at all ones

    // one stream byte as it arrives from upstream
    typedef logic [BYTE_WIDTH-1:0] byte_t;

    // packed output word
    // data[7:0] is the first byte of the pair, data[15:8] the second
    // parity makes the count of ones over all 17 bits even
    typedef struct packed {
        logic                       parity;  // bit 16
        logic [WORD_DATA_WIDTH-1:0] data;    // bits 15:0
    } word_t;

endpackage

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo import stream_pkg::*; #(
    parameter type payload_t = byte_t,        // entry type, byte or word
    parameter int  DEPTH     = BYTE_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,         // caller checks full first
    input  payload_t wr_data,
    input  logic     rd_en,         // caller checks empty first
    output payload_t rd_data,       // valid the cycle after rd_en
    output logic     empty,
    output logic     full,
    output logic     almost_full,
    output logic     almost_empty
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);  // 0..DEPTH inclusive

    payload_t mem [DEPTH];  // storage, no reset

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;       // current occupancy
    logic [CNT_WIDTH-1:0] count_next;  // occupancy after this edge

    // advance a pointer, wrapping at DEPTH-1 so any depth works
    function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // next occupancy, simultaneous read and write cancel out
    always_comb begin
        count_next = count;
        if (wr_en && !rd_en) begin
            count_next = count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count_next = count - 1'b1;
        end
    end

    // pointers, occupancy and flags
    // flags come from count_next so they match the contents after the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            empty        <= 1'b1;
            full         <= 1'b0;
            almost_full  <= 1'b0;
            almost_empty <= 1'b1;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count        <= count_next;
            empty        <= (count_next == '0);
            full         <= (count_next == CNT_WIDTH'(DEPTH));
            almost_full  <= (int'(count_next) + FIFO_AF_THRESHOLD >= DEPTH);  // free <= AF
            almost_empty <= (int'(count_next) <= FIFO_AE_THRESHOLD);
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // registered read port, holds last value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // writers and readers live outside, these catch a caller ignoring the flags
    a_no_write_when_full : assert property (
        @(posedge clk) disable iff (rst) wr_en |-> !full
    ) else $error("sync_fifo: write while full");

    a_no_read_when_empty : assert property (
        @(posedge clk) disable iff (rst) rd_en |-> !empty
    ) else $error("sync_fifo: read while empty");

endmodule

//--- hw/word_pacer.sv
`timescale 1ns/1ps

module word_pacer import stream_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hold,          // level that pauses output
    input  logic                       word_empty,
    output logic                       word_rd_en,
    input  word_t                      word_rd_data,  // registered in the fifo
    output logic                       out_strobe,    // one cycle per word
    output logic [WORD_DATA_WIDTH-1:0] out_word,
    output logic                       out_parity
);

    logic [PACE_CNT_WIDTH-1:0] pace_cnt;  // cycles left before next read allowed

    // read when spacing expired, data waiting and not held
    assign word_rd_en = (pace_cnt == '0) && !word_empty && !hold;

    // pacing down-counter
    // loads on a read so the next read comes PACE_CYCLES later
    always_ff @(posedge clk) begin
        if (rst) begin
            pace_cnt <= '0;
        end else if (word_rd_en) begin
            pace_cnt <= PACE_CNT_WIDTH'(PACE_CYCLES - 1);
        end else if (pace_cnt != '0) begin
            pace_cnt <= pace_cnt - 1'b1;
        end
    end

    // strobe lines up with the fifo read register one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rst) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= word_rd_en;
        end
    end

    // word fields straight off the fifo read register
    // it only changes on a read so it stays put between strobes
    assign out_word   = word_rd_data.data;
    assign out_parity = word_rd_data.parity;

    // spacing as seen at the output pins
    a_min_strobe_spacing : assert property (
        @(posedge clk) disable iff (rst)
        out_strobe |=> !out_strobe [*(PACE_CYCLES - 1)]
    ) else $error("word_pacer: strobes closer than PACE_CYCLES");

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stream_packer -f sources.f \
    -Mdir obj_dir -o sim_stream_packer || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_stream_packer 2>&1)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$" && echo "run passed" || { echo "run failed"; exit 1; }

//--- sim/tb_stream_packer.sv
`timescale 1ns/1ps

module tb_stream_packer import stream_pkg::*; ();

    // bytes kept with hold high across byte fifo, word fifo and the packer pair
    localparam int RETAINED = BYTE_FIFO_DEPTH + 2 * WORD_FIFO_DEPTH + 2;

    logic                        clk;
    logic                        rst;
    logic                        in_strobe;
    byte_t                       in_byte;
    logic                        hold;
    logic                        out_strobe;
    logic [WORD_DATA_WIDTH-1:0]  out_word;
    logic                        out_parity;
    logic [DROP_COUNT_WIDTH-1:0] drop_count;
    logic                        in_almost_full;
    logic                        out_almost_empty;

    byte_t exp_bytes[$];      // accepted bytes not yet seen at the output
    int    words_seen  = 0;   // output words checked so far
    int    exp_drops   = 0;   // drops the model predicts
    int    cycle       = 0;   // free-running cycle count
    int    last_strobe = 0;
    bit    have_last   = 0;
    int    min_gap     = 1000;  // tightest strobe spacing observed
    logic  hold_prev   = 1'b0;  // hold as it was one cycle back

    stream_packer_top u_stream_packer_top (
        .clk              (clk),
        .rst              (rst),
        .in_strobe        (in_strobe),
        .in_byte          (in_byte),
        .hold             (hold),
        .out_strobe       (out_strobe),
        .out_word         (out_word),
        .out_parity       (out_parity),
        .drop_count       (drop_count),
        .in_almost_full   (in_almost_full),
        .out_almost_empty (out_almost_empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_stop();
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s actual=0x%0h expected=0x%0h", $time, name, actual,
                     expected);
            fail_stop();
        end
    endtask

    // one clock then settle before driving
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // one-cycle strobe followed by gap idle cycles
    task automatic send_byte(input byte_t value, input int gap, input bit keep);
        in_strobe = 1'b1;
        in_byte   = value;
        if (keep) begin
            exp_bytes.push_back(value);
        end else begin
            exp_drops++;  // fifo expected full here
        end
        step();
        in_strobe = 1'b0;
        repeat (gap) step();
    endtask

    task automatic wait_words(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (words_seen < target && n < limit) begin
            step();
            n++;
        end
        if (words_seen < target) begin
            $display("timeout after %0d cycles waiting for %s, got %0d of %0d words", limit,
                     what, words_seen, target);
            fail_stop();
        end
    endtask

    // wait for all complete pairs while an odd byte stays behind
    task automatic drain(input string what);
        int pending;
        pending = exp_bytes.size() / 2;
        wait_words(words_seen + pending, 100 + 10 * pending, what);
    endtask

    // output checker runs mid-cycle where outputs are settled
    always @(negedge clk) begin : output_monitor
        byte_t lo;
        byte_t hi;
        logic  held;
        held      = hold_prev;
        hold_prev = hold;
        if (!rst && out_strobe) begin
            if (held) begin
                $display("output strobe at %0t although hold was high", $time);
                fail_stop();
            end else if (have_last && (cycle - last_strobe) < PACE_CYCLES) begin
                $display("output strobes %0d cycles apart at %0t, minimum is %0d",
                         cycle - last_strobe, $time, PACE_CYCLES);
                fail_stop();
            end else if (exp_bytes.size() < 2) begin
                $display("unexpected output word at %0t, fewer than two bytes pending", $time);
                fail_stop();
            end else begin
                lo = exp_bytes.pop_front();
                hi = exp_bytes.pop_front();
                check_value("out_word", 32'(out_word), 32'({hi, lo}));  // first byte low
                check_value("out_parity", 32'(out_parity), 32'($countones({hi, lo}) % 2));
                check_value("ones_in_word", 32'($countones({out_parity, out_word}) % 2), 32'd0);
                if (have_last && (cycle - last_strobe) < min_gap) begin
                    min_gap = cycle - last_strobe;
                end
                last_strobe = cycle;
                have_last   = 1'b1;
                words_seen++;
            end
        end
    end

    task automatic test_reset_state();
        check_value("out_strobe", 32'(out_strobe), 32'd0);
        check_value("drop_count", 32'(drop_count), 32'd0);
        check_value("out_almost_empty", 32'(out_almost_empty), 32'd1);
        check_value("in_almost_full", 32'(in_almost_full), 32'd0);
    endtask

    task automatic test_ordered_packing();
        int i;
        for (i = 0; i < 20; i++) begin
            send_byte(byte_t'($urandom), $urandom_range(0, 5), 1'b1);  // random spacing
        end
        drain("ordered packing words");
        check_value("drop_count", 32'(drop_count), 32'(exp_drops));
    endtask

    task automatic test_odd_byte();
        int start;
        start = words_seen;
        send_byte(8'h5a, 1, 1'b1);
        send_byte(8'ha5, 1, 1'b1);
        send_byte(8'h3c, 1, 1'b1);   // left without a partner
        wait_words(start + 1, 200, "first word of odd group");
        repeat (40) step();          // quiet window where the monitor flags any strobe
        check_value("words_seen", 32'(words_seen), 32'(start + 1));
        send_byte(8'hc3, 1, 1'b1);
        wait_words(start + 2, 200, "word closing odd group");
    endtask

    task automatic test_pacing_hold();
        int i;
        int held;
        for (i = 0; i < 12; i++) begin
            send_byte(byte_t'($urandom), 0, 1'b1);  // back to back
        end
        wait_words(words_seen + 2, 200, "words before hold");
        hold = 1'b1;
        step();
        step();      // a strobe already in flight is past now
        held = words_seen;
        for (i = 0; i < 8; i++) begin
            send_byte(byte_t'($urandom), 2, 1'b1);
        end
        repeat (60) step();
        check_value("words_seen", 32'(words_seen), 32'(held));
        hold = 1'b0;
        drain("words after hold release");
        check_value("min_strobe_gap", 32'(min_gap), 32'(PACE_CYCLES));  // backlog runs at full rate
    endtask

    task automatic test_overflow();
        int i;
        int start;
        hold = 1'b1;
        step();
        step();
        start = words_seen;
        for (i = 0; i < 50; i++) begin
            send_byte(byte_t'($urandom), 7, i < RETAINED);  // 8 cycles apart
        end
        repeat (4) step();
        check_value("drop_count", 32'(drop_count), 32'(exp_drops));
        check_value("in_almost_full", 32'(in_almost_full), 32'd1);
        check_value("out_almost_empty", 32'(out_almost_empty), 32'd0);
        hold = 1'b0;
        wait_words(start + RETAINED / 2, 600, "words retained during overflow");
        repeat (40) step();
        check_value("words_seen", 32'(words_seen), 32'(start + RETAINED / 2));
        send_byte(8'h81, 1, 1'b1);
        wait_words(start + RETAINED / 2 + 1, 200, "word pairing the waiting byte");
    endtask

    task automatic test_almost_empty();
        int i;
        int start;
        hold = 1'b1;
        step();
        step();
        start = words_seen;
        check_value("out_almost_empty", 32'(out_almost_empty), 32'd1);
        for (i = 0; i < 6; i++) begin
            send_byte(byte_t'($urandom), 1, 1'b1);
        end
        repeat (30) step();  // three words settle in the word fifo
        check_value("out_almost_empty", 32'(out_almost_empty), 32'd0);
        hold = 1'b0;
        wait_words(start + 2, 200, "two of three stored words");
        check_value("out_almost_empty", 32'(out_almost_empty), 32'd1);  // one word left
        drain("last stored word");
        repeat (4) step();
        check_value("out_almost_empty", 32'(out_almost_empty), 32'd1);
    endtask

    initial begin : main_sequence
        rst       = 1'b1;
        in_strobe = 1'b0;
        in_byte   = '0;
        hold      = 1'b0;
        void'($urandom(32'h7f3a_2b7f));  // fixed seed for the whole run
        repeat (16) step();
        rst = 1'b0;
        step();
        test_reset_state();
        test_ordered_packing();
        test_odd_byte();
        test_pacing_hold();
        test_overflow();
        test_almost_empty();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- sources.f
hw/stream_pkg.sv
hw/sync_fifo.sv
hw/byte_intake.sv
hw/byte_packer.sv
hw/word_pacer.sv
hw/stream_packer_top.sv
sim/tb_stream_packer.sv
